// ==== Makefile ====
SIM := obj_dir/Vbpred_tb

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log; cat sim.log
	grep -qx "TEST OK" sim.log

$(SIM): branch_predictor_top.f $(wildcard logic/*.sv) $(wildcard bench/*.sv bench/*.svh)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f branch_predictor_top.f --top-module bpred_tb

clean:
	rm -rf obj_dir sim.log

// ==== bench/bpred_model.svh ====
// reference model of the predictor state with lookup, training and next-pc functions
`ifndef BPRED_MODEL_SVH
`define BPRED_MODEL_SVH

logic [31:0]             m_btb_target [NUM_BTB_ENTRIES];
logic [31:0]             m_btb_tag    [NUM_BTB_ENTRIES];
bit                      m_btb_jump   [NUM_BTB_ENTRIES];
bit                      m_btb_valid  [NUM_BTB_ENTRIES];
logic [1:0]              m_pht        [1 << NUM_GHR_BITS];
logic [NUM_GHR_BITS-1:0] m_ghr;
logic [31:0]             m_pc;  // pc the dut holds after the coming edge

function automatic int btb_slot(input logic [31:0] pc);
    return int'((pc >> 2) % NUM_BTB_ENTRIES);
endfunction

function automatic logic [NUM_GHR_BITS-1:0] gshare_index(input logic [31:0] pc);
    logic [NUM_GHR_BITS-1:0] word_bits;
    word_bits = NUM_GHR_BITS'(pc >> 2);
    return word_bits ^ m_ghr;
endfunction

function automatic logic is_taken_transfer(input logic [6:0] op, input logic taken);
    return (op == op_jal) || (op == op_jalr) || (op == op_branch && taken);
endfunction

function automatic logic [31:0] actual_next(input logic [31:0] pc, input logic taken,
                                            input logic [31:0] target);
    return taken ? target : pc + 32'd4;
endfunction

function automatic logic mispredict_expected(input logic valid, input logic [31:0] pc,
                                             input logic taken, input logic [31:0] target,
                                             input logic [31:0] pred_next);
    return valid && (actual_next(pc, taken, target) != pred_next);
endfunction

function automatic logic taken_expected(input logic [31:0] pc);
    int slot;
    slot = btb_slot(pc);
    if (!m_btb_valid[slot] || m_btb_tag[slot] != pc) begin
        return 1'b0;
    end
    return m_btb_jump[slot] || m_pht[gshare_index(pc)][1];
endfunction

function automatic logic [31:0] next_pc_expected(input logic [31:0] pc, input logic wr_en,
                                                 input logic [31:0] wr_pc,
                                                 input logic [31:0] wr_target);
    int slot;
    slot = btb_slot(pc);
    if (!taken_expected(pc)) begin
        return pc + 32'd4;
    end
    if (wr_en && btb_slot(wr_pc) == slot) begin
        return wr_target;  // slot rewritten this cycle
    end
    return m_btb_target[slot];
endfunction

task automatic reset_model();
    for (int i = 0; i < NUM_BTB_ENTRIES; i++) begin
        m_btb_valid[i] = 1'b0;
    end
    for (int i = 0; i < (1 << NUM_GHR_BITS); i++) begin
        m_pht[i] = ctr_weak_not_taken;
    end
    m_ghr = '0;
    m_pc  = reset_pc;
endtask

task automatic advance_model(input logic stall, input logic valid, input logic [31:0] pc,
                             input logic [6:0] op, input logic taken,
                             input logic [31:0] target, input logic [NUM_GHR_BITS-1:0] idx,
                             input logic [31:0] pred_next);
    logic [31:0] fetch_next;
    logic        write_btb;
    int          slot;
    write_btb  = valid && is_taken_transfer(op, taken);
    fetch_next = next_pc_expected(m_pc, write_btb, pc, target);
    if (write_btb) begin
        slot               = btb_slot(pc);
        m_btb_valid[slot]  = 1'b1;
        m_btb_tag[slot]    = pc;
        m_btb_target[slot] = target;
        m_btb_jump[slot]   = (op != op_branch);
    end
    if (valid && op == op_branch) begin
        if (taken && m_pht[idx] != ctr_max) begin
            m_pht[idx] = m_pht[idx] + 2'd1;
        end else if (!taken && m_pht[idx] != ctr_min) begin
            m_pht[idx] = m_pht[idx] - 2'd1;
        end
        m_ghr = {m_ghr[NUM_GHR_BITS-2:0], taken};
    end
    if (mispredict_expected(valid, pc, taken, target, pred_next)) begin
        m_pc = actual_next(pc, taken, target);
    end else if (!stall) begin
        m_pc = fetch_next;
    end
endtask

`endif

// ==== bench/bpred_tb.sv ====
// testbench for the branch predictor: clock, reset, directed and random resolves, checks
module bpred_tb
    import bpred_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_BTB_ENTRIES = 32;
    localparam int NUM_GHR_BITS    = 5;

    localparam logic [31:0] jump_src_pc  = 32'h0000_307c;  // helper jal, btb slot 31
    localparam logic [31:0] jal_pc       = 32'h0000_1040;
    localparam logic [31:0] jal_target   = 32'h0000_1100;
    localparam logic [31:0] br_pc        = 32'h0000_1200;
    localparam logic [31:0] br_target    = 32'h0000_1240;
    localparam logic [31:0] nt_pc        = 32'h0000_1404;
    localparam logic [31:0] hist_pc      = 32'h0000_1308;
    localparam logic [31:0] hist_target  = 32'h0000_1340;
    localparam logic [31:0] mp_pc        = 32'h0000_1500;
    localparam logic [31:0] alias_pc     = jal_pc + 32'(NUM_BTB_ENTRIES * 4);  // same slot
    localparam logic [31:0] alias_target = 32'h0000_1180;

    logic                    clk;
    logic                    reset_i;
    logic                    stall_i;
    logic                    ex_valid_i;
    logic [31:0]             ex_pc_i;
    logic [6:0]              ex_op_i;
    logic                    ex_taken_i;
    logic [31:0]             ex_target_i;
    logic [NUM_GHR_BITS-1:0] ex_pht_index_i;
    logic [31:0]             ex_pred_next_i;
    logic [31:0]             pc_o;
    logic [31:0]             pred_next_o;
    logic                    pred_taken_o;
    logic [NUM_GHR_BITS-1:0] pht_index_o;
    logic                    mispredict_o;

    string test_name;
    int    addr_errors  = 0;
    int    flag_errors  = 0;
    int    index_errors = 0;
    int    wait_errors  = 0;

    `include "bpred_model.svh"

    branch_predictor_top #(
        .NUM_BTB_ENTRIES (NUM_BTB_ENTRIES),
        .NUM_GHR_BITS    (NUM_GHR_BITS)
    ) branch_predictor_top_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .stall_i        (stall_i),
        .ex_valid_i     (ex_valid_i),
        .ex_pc_i        (ex_pc_i),
        .ex_op_i        (ex_op_i),
        .ex_taken_i     (ex_taken_i),
        .ex_target_i    (ex_target_i),
        .ex_pht_index_i (ex_pht_index_i),
        .ex_pred_next_i (ex_pred_next_i),
        .pc_o           (pc_o),
        .pred_next_o    (pred_next_o),
        .pred_taken_o   (pred_taken_o),
        .pht_index_o    (pht_index_o),
        .mispredict_o   (mispredict_o)
    );

    always #4 clk = ~clk;

    task automatic addr_check(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            addr_errors++;
            $display("CHECK FAILED %s %s: expected %h actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic flag_check(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            flag_errors++;
            $display("CHECK FAILED %s %s: expected %b actual %b",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic index_check(input string what, input logic [NUM_GHR_BITS-1:0] expected,
                               input logic [NUM_GHR_BITS-1:0] actual);
        if (actual !== expected) begin
            index_errors++;
            $display("CHECK FAILED %s %s: expected %h actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    // outputs are stable at the falling edge, model then steps past the next rising edge
    always @(negedge clk) begin
        if (reset_i) begin
            reset_model();
        end else begin
            addr_check("pc_o", m_pc, pc_o);
            flag_check("pred_taken_o", taken_expected(m_pc), pred_taken_o);
            addr_check("pred_next_o",
                       next_pc_expected(m_pc, ex_valid_i && is_taken_transfer(ex_op_i, ex_taken_i),
                                        ex_pc_i, ex_target_i),
                       pred_next_o);
            index_check("pht_index_o", gshare_index(m_pc), pht_index_o);
            flag_check("mispredict_o",
                       mispredict_expected(ex_valid_i, ex_pc_i, ex_taken_i, ex_target_i,
                                           ex_pred_next_i),
                       mispredict_o);
            advance_model(stall_i, ex_valid_i, ex_pc_i, ex_op_i, ex_taken_i, ex_target_i,
                          ex_pht_index_i, ex_pred_next_i);
        end
    end

    task automatic to_drive_point();
        @(posedge clk);
        #1;
    endtask

    // one-cycle execute outcome
    task automatic send_resolve(input logic [6:0] op, input logic [31:0] pc, input logic taken,
                                input logic [31:0] target, input logic [NUM_GHR_BITS-1:0] idx,
                                input logic [31:0] pred_next);
        ex_valid_i     = 1'b1;
        ex_op_i        = op;
        ex_pc_i        = pc;
        ex_taken_i     = taken;
        ex_target_i    = target;
        ex_pht_index_i = idx;
        ex_pred_next_i = pred_next;
        to_drive_point();
        ex_valid_i     = 1'b0;
    endtask

    // mispredicted jal steers fetch, history and counters untouched
    task automatic redirect_fetch(input logic [31:0] addr);
        send_resolve(op_jal, jump_src_pc, 1'b1, addr, '0, jump_src_pc + 32'd4);
    endtask

    task automatic wait_for_pc(input logic [31:0] addr, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (pc_o !== addr && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (pc_o !== addr) begin
            wait_errors++;
            $display("wait failed in %s: pc did not reach %h within %0d cycles",
                     test_name, addr, limit);
        end
    endtask

    initial begin
        int                      pick;
        logic [NUM_GHR_BITS-1:0] taken_idx;
        logic [NUM_GHR_BITS-1:0] other_idx;
        void'($urandom(32'h158b_634d));
        test_name      = "reset";
        clk            = 1'b0;
        reset_i        = 1'b1;
        stall_i        = 1'b0;
        ex_valid_i     = 1'b0;
        ex_pc_i        = '0;
        ex_op_i        = '0;
        ex_taken_i     = 1'b0;
        ex_target_i    = '0;
        ex_pht_index_i = '0;
        ex_pred_next_i = '0;
        repeat (8) @(posedge clk);
        #1;
        reset_i = 1'b0;

        test_name = "reset_step";
        @(negedge clk);
        addr_check("pc after reset", reset_pc, pc_o);
        flag_check("pred_taken after reset", 1'b0, pred_taken_o);
        for (int k = 1; k <= 4; k++) begin
            to_drive_point();
            @(negedge clk);
            addr_check("pc step", reset_pc + 32'(4 * k), pc_o);
            flag_check("pred_taken step", 1'b0, pred_taken_o);
        end
        to_drive_point();
        stall_i = 1'b1;
        for (int k = 0; k < 3; k++) begin
            @(negedge clk);
            addr_check("pc held by stall", reset_pc + 32'd20, pc_o);
            to_drive_point();
        end
        stall_i = 1'b0;

        test_name = "jal_alloc";
        send_resolve(op_jal, jal_pc, 1'b1, jal_target, '0, jal_pc + 32'd4);
        redirect_fetch(jal_pc);
        wait_for_pc(jal_pc, 4);
        flag_check("pred_taken at jal pc", 1'b1, pred_taken_o);
        addr_check("pred_next at jal pc", jal_target, pred_next_o);
        to_drive_point();

        test_name = "gshare_taken";
        for (int k = 0; k < 8; k++) begin
            send_resolve(op_branch, br_pc, 1'b1, br_target, gshare_index(br_pc), br_target);
        end
        taken_idx = NUM_GHR_BITS'(br_pc >> 2) ^ {NUM_GHR_BITS{1'b1}};  // history all ones
        other_idx = taken_idx ^ NUM_GHR_BITS'(1);
        redirect_fetch(br_pc);
        wait_for_pc(br_pc, 4);
        index_check("index at branch pc", taken_idx, pht_index_o);
        flag_check("pred_taken after taken training", 1'b1, pred_taken_o);
        addr_check("pred_next after taken training", br_target, pred_next_o);
        to_drive_point();

        test_name = "gshare_not_taken";
        for (int k = 0; k < 4; k++) begin
            send_resolve(op_branch, nt_pc, 1'b0, br_target, taken_idx, nt_pc + 32'd4);
        end
        for (int k = 0; k < NUM_GHR_BITS; k++) begin
            send_resolve(op_branch, hist_pc, 1'b1, hist_target, other_idx, hist_target);
        end
        redirect_fetch(br_pc);
        wait_for_pc(br_pc, 4);
        index_check("index with history refilled", taken_idx, pht_index_o);
        flag_check("pred_taken at ctr_min", 1'b0, pred_taken_o);
        to_drive_point();
        send_resolve(op_branch, br_pc, 1'b1, br_target, taken_idx, br_target);
        redirect_fetch(br_pc);
        wait_for_pc(br_pc, 4);
        flag_check("pred_taken one above ctr_min", 1'b0, pred_taken_o);
        to_drive_point();
        send_resolve(op_branch, br_pc, 1'b1, br_target, taken_idx, br_target);
        redirect_fetch(br_pc);
        wait_for_pc(br_pc, 4);
        flag_check("pred_taken two above ctr_min", 1'b1, pred_taken_o);
        to_drive_point();

        test_name = "mispredict";
        stall_i        = 1'b1;
        ex_valid_i     = 1'b1;
        ex_op_i        = op_branch;
        ex_pc_i        = mp_pc;
        ex_taken_i     = 1'b0;
        ex_target_i    = mp_pc + 32'h100;
        ex_pht_index_i = '0;
        ex_pred_next_i = mp_pc + 32'h100;  // fetch guessed taken
        @(negedge clk);
        flag_check("mispredict in resolve cycle", 1'b1, mispredict_o);
        to_drive_point();
        ex_valid_i = 1'b0;
        @(negedge clk);
        addr_check("pc after mispredict under stall", mp_pc + 32'd4, pc_o);
        flag_check("mispredict after resolve cycle", 1'b0, mispredict_o);
        to_drive_point();
        stall_i = 1'b0;

        test_name = "btb_alias";
        redirect_fetch(alias_pc);
        wait_for_pc(alias_pc, 4);
        flag_check("alias before alloc", 1'b0, pred_taken_o);
        addr_check("alias next before alloc", alias_pc + 32'd4, pred_next_o);
        to_drive_point();
        send_resolve(op_jal, alias_pc, 1'b1, alias_target, '0, alias_pc + 32'd4);
        redirect_fetch(alias_pc);
        wait_for_pc(alias_pc, 4);
        flag_check("alias after alloc", 1'b1, pred_taken_o);
        addr_check("alias next after alloc", alias_target, pred_next_o);
        to_drive_point();
        redirect_fetch(jal_pc);
        wait_for_pc(jal_pc, 4);
        flag_check("original pc after replace", 1'b0, pred_taken_o);
        addr_check("original next after replace", jal_pc + 32'd4, pred_next_o);
        to_drive_point();

        test_name = "random";
        for (int i = 0; i < 400; i++) begin
            stall_i = (($urandom % 4) == 0);
            if ($urandom % 3 == 0) begin
                pick           = $urandom % 3;
                ex_op_i        = (pick == 0) ? op_branch : (pick == 1) ? op_jal : op_jalr;
                ex_pc_i        = 32'h1000 + (($urandom % 64) << 2);
                ex_target_i    = 32'h1000 + (($urandom % 64) << 2);
                ex_taken_i     = (ex_op_i != op_branch) || 1'($urandom);
                ex_pht_index_i = NUM_GHR_BITS'($urandom);
                ex_pred_next_i = ($urandom % 2) ? ex_target_i : ex_pc_i + 32'd4;
                ex_valid_i     = 1'b1;
            end else begin
                ex_valid_i = 1'b0;
            end
            to_drive_point();
        end
        ex_valid_i = 1'b0;
        stall_i    = 1'b0;
        repeat (2) to_drive_point();

        $display("errors: addr %0d flag %0d index %0d wait %0d",
                 addr_errors, flag_errors, index_errors, wait_errors);
        if (addr_errors + flag_errors + index_errors + wait_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== branch_predictor_top.f ====
+incdir+bench
logic/bpred_pkg.sv
logic/branch_target_buffer.sv
logic/gshare_predictor.sv
logic/fetch_pc_unit.sv
logic/branch_resolve.sv
logic/branch_predictor_top.sv
bench/bpred_tb.sv

// ==== logic/bpred_pkg.sv ====
// opcode constants, reset pc and two-bit counter encodings for the branch predictor
package bpred_pkg;

    // rv32i major opcodes of the control instructions
    localparam logic [6:0] op_branch = 7'b1100011;  // beq, bne, blt, ...
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // first fetch address after reset
    localparam logic [31:0] reset_pc = 32'h0000_1000;

    // two-bit saturating counter states, upper bit is the direction
    localparam logic [1:0] ctr_min            = 2'b00;  // strongly not taken
    localparam logic [1:0] ctr_weak_not_taken = 2'b01;  // reset value
    localparam logic [1:0] ctr_max            = 2'b11;  // strongly taken

endpackage

// ==== logic/branch_predictor_top.sv ====
// branch predictor top: pc unit, btb, gshare predictor and resolve logic
module branch_predictor_top #(
    parameter int NUM_BTB_ENTRIES = 32,
    parameter int NUM_GHR_BITS    = 5
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    stall_i,
    input  logic                    ex_valid_i,
    input  logic [31:0]             ex_pc_i,
    input  logic [6:0]              ex_op_i,
    input  logic                    ex_taken_i,
    input  logic [31:0]             ex_target_i,
    input  logic [NUM_GHR_BITS-1:0] ex_pht_index_i,
    input  logic [31:0]             ex_pred_next_i,
    output logic [31:0]             pc_o,
    output logic [31:0]             pred_next_o,
    output logic                    pred_taken_o,
    output logic [NUM_GHR_BITS-1:0] pht_index_o,
    output logic                    mispredict_o
);

    logic                    btb_hit;
    logic                    btb_is_jump;
    logic                    btb_is_branch;
    logic [31:0]             btb_target;
    logic                    dir_taken;
    logic                    btb_we;
    logic                    btb_wr_is_jump;
    logic                    pht_we;
    logic [NUM_GHR_BITS-1:0] pht_wr_index;
    logic                    pht_inc;
    logic                    hist_shift;
    logic                    hist_taken;
    logic                    redirect;
    logic [31:0]             redirect_pc;

    assign mispredict_o = redirect;

    fetch_pc_unit fetch_pc_unit_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .stall_i         (stall_i),
        .redirect_i      (redirect),
        .redirect_pc_i   (redirect_pc),
        .btb_hit_i       (btb_hit),
        .btb_is_jump_i   (btb_is_jump),
        .btb_is_branch_i (btb_is_branch),
        .btb_target_i    (btb_target),
        .dir_taken_i     (dir_taken),
        .pc_o            (pc_o),
        .pred_taken_o    (pred_taken_o),
        .pred_next_o     (pred_next_o)
    );

    branch_target_buffer #(
        .NUM_BTB_ENTRIES (NUM_BTB_ENTRIES)
    ) branch_target_buffer_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .lookup_pc_i  (pc_o),
        .wr_en_i      (btb_we),
        .wr_pc_i      (ex_pc_i),      // index and tag
        .wr_target_i  (ex_target_i),
        .wr_is_jump_i (btb_wr_is_jump),
        .hit_o        (btb_hit),
        .is_jump_o    (btb_is_jump),
        .is_branch_o  (btb_is_branch),
        .target_o     (btb_target)
    );

    gshare_predictor #(
        .NUM_GHR_BITS (NUM_GHR_BITS)
    ) gshare_predictor_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .lookup_pc_i     (pc_o),
        .train_en_i      (pht_we),
        .train_index_i   (pht_wr_index),
        .train_inc_i     (pht_inc),
        .hist_shift_i    (hist_shift),
        .hist_taken_i    (hist_taken),
        .index_o         (pht_index_o),
        .predict_taken_o (dir_taken)
    );

    branch_resolve #(
        .NUM_GHR_BITS (NUM_GHR_BITS)
    ) branch_resolve_i (
        .ex_valid_i     (ex_valid_i),
        .ex_pc_i        (ex_pc_i),
        .ex_op_i        (ex_op_i),
        .ex_taken_i     (ex_taken_i),
        .ex_target_i    (ex_target_i),
        .ex_pht_index_i (ex_pht_index_i),
        .ex_pred_next_i (ex_pred_next_i),
        .btb_we_o       (btb_we),
        .btb_is_jump_o  (btb_wr_is_jump),
        .pht_we_o       (pht_we),
        .pht_index_o    (pht_wr_index),
        .pht_inc_o      (pht_inc),
        .hist_shift_o   (hist_shift),
        .hist_taken_o   (hist_taken),
        .redirect_o     (redirect),
        .redirect_pc_o  (redirect_pc)
    );

endmodule

// ==== logic/branch_resolve.sv ====
// resolve logic: actual next pc, mispredict and training strobes for btb, pht and ghr
module branch_resolve
    import bpred_pkg::*;
#(
    parameter int NUM_GHR_BITS = 5
) (
    input  logic                    ex_valid_i,
    input  logic [31:0]             ex_pc_i,
    input  logic [6:0]              ex_op_i,
    input  logic                    ex_taken_i,
    input  logic [31:0]             ex_target_i,
    input  logic [NUM_GHR_BITS-1:0] ex_pht_index_i,
    input  logic [31:0]             ex_pred_next_i,
    output logic                    btb_we_o,
    output logic                    btb_is_jump_o,
    output logic                    pht_we_o,
    output logic [NUM_GHR_BITS-1:0] pht_index_o,
    output logic                    pht_inc_o,
    output logic                    hist_shift_o,
    output logic                    hist_taken_o,
    output logic                    redirect_o,
    output logic [31:0]             redirect_pc_o
);

    logic        is_cond;
    logic        is_jump;
    logic [31:0] actual_next;

    // opcode class
    assign is_cond = (ex_op_i == op_branch);
    assign is_jump = (ex_op_i == op_jal) || (ex_op_i == op_jalr);

    assign actual_next = ex_taken_i ? ex_target_i : ex_pc_i + 32'd4;

    // fetch guessed wrong if its next pc is not where execute went
    assign redirect_o    = ex_valid_i && (actual_next != ex_pred_next_i);
    assign redirect_pc_o = actual_next;

    // btb allocates on every taken transfer
    assign btb_we_o      = ex_valid_i && (is_jump || (is_cond && ex_taken_i));
    assign btb_is_jump_o = is_jump;

    // counters and history only see conditional branches
    assign pht_we_o     = ex_valid_i && is_cond;
    assign pht_index_o  = ex_pht_index_i;  // index fetch used, not recomputed
    assign pht_inc_o    = ex_taken_i;
    assign hist_shift_o = ex_valid_i && is_cond;
    assign hist_taken_o = ex_taken_i;

endmodule

// ==== logic/branch_target_buffer.sv ====
// direct-mapped branch target buffer with full-pc tags, type flag and write bypass
module branch_target_buffer #(
    parameter int NUM_BTB_ENTRIES = 32
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic [31:0] lookup_pc_i,
    input  logic        wr_en_i,
    input  logic [31:0] wr_pc_i,
    input  logic [31:0] wr_target_i,
    input  logic        wr_is_jump_i,
    output logic        hit_o,
    output logic        is_jump_o,
    output logic        is_branch_o,
    output logic [31:0] target_o
);

    localparam int IDX_BITS = $clog2(NUM_BTB_ENTRIES);

    logic [31:0]                target_mem [NUM_BTB_ENTRIES];
    logic [31:0]                tag_mem    [NUM_BTB_ENTRIES];
    logic                       jump_mem   [NUM_BTB_ENTRIES];  // 1 = jal/jalr, 0 = branch
    logic [NUM_BTB_ENTRIES-1:0] valid_q;

    logic [IDX_BITS-1:0] rd_idx;
    logic [IDX_BITS-1:0] wr_idx;
    logic                rd_valid;
    logic                rd_tag_match;
    logic                rd_is_jump;

    assign rd_idx = lookup_pc_i[IDX_BITS+1:2];  // word address bits
    assign wr_idx = wr_pc_i[IDX_BITS+1:2];

    // read side
    assign rd_valid     = valid_q[rd_idx];
    assign rd_tag_match = (tag_mem[rd_idx] == lookup_pc_i);
    assign rd_is_jump   = jump_mem[rd_idx];

    assign hit_o       = rd_valid && rd_tag_match;
    assign is_jump_o   = rd_valid && rd_is_jump;
    assign is_branch_o = rd_valid && !rd_is_jump;

    // a target being rewritten this cycle is seen right away
    always_comb begin
        if (wr_en_i && (wr_idx == rd_idx)) begin
            target_o = wr_target_i;
        end else begin
            target_o = target_mem[rd_idx];
        end
    end

    // valid bits
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // entry payload, every taken transfer overwrites its slot
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            target_mem[wr_idx] <= wr_target_i;
            tag_mem[wr_idx]    <= wr_pc_i;
            jump_mem[wr_idx]   <= wr_is_jump_i;
        end
    end

    // resolve logic must never hand us an unknown write strobe
    a_wr_en_known : assert property (
        @(posedge clk) disable iff (reset_i) !$isunknown(wr_en_i)
    ) else $error("btb write enable unknown");

endmodule

// ==== logic/fetch_pc_unit.sv ====
// fetch program counter register and predicted next-pc selection
module fetch_pc_unit
    import bpred_pkg::*;
(
    input  logic        clk,
    input  logic        reset_i,
    input  logic        stall_i,
    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,
    input  logic        btb_hit_i,
    input  logic        btb_is_jump_i,
    input  logic        btb_is_branch_i,
    input  logic [31:0] btb_target_i,
    input  logic        dir_taken_i,
    output logic [31:0] pc_o,
    output logic        pred_taken_o,
    output logic [31:0] pred_next_o
);

    logic [31:0] pc_q;
    logic [31:0] pc_plus4;

    assign pc_o     = pc_q;
    assign pc_plus4 = pc_q + 32'd4;

    // jumps always taken, branches follow the counter
    assign pred_taken_o = btb_hit_i && (btb_is_jump_i || (btb_is_branch_i && dir_taken_i));
    assign pred_next_o  = pred_taken_o ? btb_target_i : pc_plus4;

    // redirect beats stall so a resolve during a stall still lands
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= reset_pc;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (!stall_i) begin
            pc_q <= pred_next_o;
        end
    end

    // targets from the btb and from execute are word addresses
    a_pc_aligned : assert property (
        @(posedge clk) disable iff (reset_i) pc_o[1:0] == 2'b00
    ) else $error("fetch pc not word aligned: %h", pc_o);

endmodule

// ==== logic/gshare_predictor.sv ====
// gshare direction predictor: global history register and two-bit counter table
module gshare_predictor
    import bpred_pkg::*;
#(
    parameter int NUM_GHR_BITS = 5
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [31:0]             lookup_pc_i,
    input  logic                    train_en_i,
    input  logic [NUM_GHR_BITS-1:0] train_index_i,
    input  logic                    train_inc_i,
    input  logic                    hist_shift_i,
    input  logic                    hist_taken_i,
    output logic [NUM_GHR_BITS-1:0] index_o,
    output logic                    predict_taken_o
);

    localparam int NUM_CTRS = 1 << NUM_GHR_BITS;

    logic [NUM_GHR_BITS-1:0] ghr_q;
    logic [1:0]              pht_q [NUM_CTRS];
    logic [1:0]              train_ctr;

    assign index_o         = lookup_pc_i[NUM_GHR_BITS+1:2] ^ ghr_q;
    assign predict_taken_o = pht_q[index_o][1];  // upper bit is the direction

    assign train_ctr = pht_q[train_index_i];

    // counter table, saturating at both ends
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_CTRS; i++) begin
                pht_q[i] <= ctr_weak_not_taken;
            end
        end else if (train_en_i) begin
            if (train_inc_i) begin
                if (train_ctr != ctr_max) begin
                    pht_q[train_index_i] <= train_ctr + 2'd1;
                end
            end else begin
                if (train_ctr != ctr_min) begin
                    pht_q[train_index_i] <= train_ctr - 2'd1;
                end
            end
        end
    end

    // history, newest outcome in bit 0
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ghr_q <= '0;
        end else if (hist_shift_i) begin
            ghr_q <= {ghr_q[NUM_GHR_BITS-2:0], hist_taken_i};
        end
    end

    // index comes back from execute, carried through the pipeline
    a_train_index_known : assert property (
        @(posedge clk) disable iff (reset_i) train_en_i |-> !$isunknown(train_index_i)
    ) else $error("pht training index unknown");

endmodule
